// ==== common/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////////////////////

    // Encoded from the decode stage, one op per instruction
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        // Upper-immediate loads pass the second argument
        ALU_PASS_B = 4'd10
    } alu_op_t;

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding and memory access
    ////////////////////////////////////////////////////////////////////////////

    // Operand source, ordered as register, WB, MEM
    typedef enum logic [1:0] {
        FWD_REG = 2'd0,
        FWD_WB  = 2'd1,
        FWD_MEM = 2'd2
    } fwd_sel_t;

    // Access size handed on to the memory stage
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

endpackage

`default_nettype wire

// ==== common/fwd_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface fwd_if #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32
);

    localparam int REG_SEL = $clog2(NUM_REGS);

    // MEM source, the EX/MEM register outputs
    logic [REG_SEL-1:0]   mem_rd;
    logic                 mem_reg_write;
    logic [WORD_SIZE-1:0] mem_value;

    // WB source, from the write-back stage
    logic [REG_SEL-1:0]   wb_rd;
    logic                 wb_reg_write;
    logic [WORD_SIZE-1:0] wb_value;

    // Driven by the pipeline register
    modport mem_src (output mem_rd, mem_reg_write, mem_value);

    // Driven from the write-back ports at the top
    modport wb_src (output wb_rd, wb_reg_write, wb_value);

    // Forwarding unit and operand muxes
    modport sink (
        input mem_rd, mem_reg_write, mem_value,
        input wb_rd, wb_reg_write, wb_value
    );

endinterface

`default_nettype wire

// ==== design/forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_unit #(
    parameter int NUM_REGS  = 32,
    parameter int WORD_SIZE = 32
) (
    input  logic [$clog2(NUM_REGS)-1:0] rs1,
    input  logic [$clog2(NUM_REGS)-1:0] rs2,
    fwd_if.sink                         fwd,
    output ex_pkg::fwd_sel_t            sel_forward1,
    output ex_pkg::fwd_sel_t            sel_forward2
);

    logic mem_live;
    logic wb_live;
    logic mem_hit1;
    logic mem_hit2;
    logic wb_hit1;
    logic wb_hit2;

    // A source only counts if it writes a real register (x0 never forwards)
    assign mem_live = fwd.mem_reg_write && (fwd.mem_rd != '0);
    assign wb_live  = fwd.wb_reg_write && (fwd.wb_rd != '0);

    // Destination matches per operand
    assign mem_hit1 = mem_live && (fwd.mem_rd == rs1);
    assign mem_hit2 = mem_live && (fwd.mem_rd == rs2);
    assign wb_hit1  = wb_live && (fwd.wb_rd == rs1);
    assign wb_hit2  = wb_live && (fwd.wb_rd == rs2);

    // MEM is younger so it wins over WB
    always_comb begin
        if (mem_hit1) begin
            sel_forward1 = ex_pkg::FWD_MEM;
        end else if (wb_hit1) begin
            sel_forward1 = ex_pkg::FWD_WB;
        end else begin
            sel_forward1 = ex_pkg::FWD_REG;
        end
    end

    // Same rule for the second operand
    always_comb begin
        if (mem_hit2) begin
            sel_forward2 = ex_pkg::FWD_MEM;
        end else if (wb_hit2) begin
            sel_forward2 = ex_pkg::FWD_WB;
        end else begin
            sel_forward2 = ex_pkg::FWD_REG;
        end
    end

endmodule

`default_nettype wire

// ==== ex_stage/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu #(
    parameter int WORD_SIZE = 32
) (
    input  ex_pkg::alu_op_t       alu_op,
    input  logic [WORD_SIZE-1:0]  arg1,
    input  logic [WORD_SIZE-1:0]  arg2,
    output logic [WORD_SIZE-1:0]  result,
    output logic                  zero,
    output logic                  pos
);

    localparam int SHAMT_W = $clog2(WORD_SIZE);

    logic [SHAMT_W-1:0] shamt;
    logic               lt_signed;
    logic               lt_unsigned;

    // Shift amount from the low bits only
    assign shamt = arg2[SHAMT_W-1:0];

    // Comparisons for SLT and SLTU
    assign lt_signed   = $signed(arg1) < $signed(arg2);
    assign lt_unsigned = arg1 < arg2;

    ////////////////////////////////////////////////////////////////////////////
    // Operation select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (alu_op)
            ex_pkg::ALU_ADD: begin
                result = arg1 + arg2;
            end
            ex_pkg::ALU_SUB: begin
                result = arg1 - arg2;
            end
            ex_pkg::ALU_SLL: begin
                result = arg1 << shamt;
            end
            ex_pkg::ALU_SLT: begin
                result = {{(WORD_SIZE-1){1'b0}}, lt_signed};
            end
            ex_pkg::ALU_SLTU: begin
                result = {{(WORD_SIZE-1){1'b0}}, lt_unsigned};
            end
            ex_pkg::ALU_XOR: begin
                result = arg1 ^ arg2;
            end
            ex_pkg::ALU_SRL: begin
                result = arg1 >> shamt;
            end
            ex_pkg::ALU_SRA: begin
                // Arithmetic shift keeps the sign
                result = $unsigned($signed(arg1) >>> shamt);
            end
            ex_pkg::ALU_OR: begin
                result = arg1 | arg2;
            end
            ex_pkg::ALU_AND: begin
                result = arg1 & arg2;
            end
            ex_pkg::ALU_PASS_B: begin
                // LUI style, immediate straight through
                result = arg2;
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Flags for branch decisions downstream
    assign zero = (result == '0);
    // Strictly above zero when read as signed
    assign pos  = !result[WORD_SIZE-1] && !zero;

endmodule

`default_nettype wire

// ==== ex_stage/ex_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_stage #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32
) (
    input  logic [WORD_SIZE-1:0]  data1,
    input  logic [WORD_SIZE-1:0]  data2,
    input  logic [WORD_SIZE-1:0]  immd,
    fwd_if.sink                   fwd,
    input  ex_pkg::fwd_sel_t      sel_forward1,
    input  ex_pkg::fwd_sel_t      sel_forward2,
    input  ex_pkg::alu_op_t       alu_op,
    input  logic                  alu_src,
    output logic [WORD_SIZE-1:0]  result,
    output logic [WORD_SIZE-1:0]  save_data,
    output logic                  zero,
    output logic                  pos
);

    logic [WORD_SIZE-1:0] alu1;
    logic [WORD_SIZE-1:0] fwd2;
    logic [WORD_SIZE-1:0] alu2;

    ////////////////////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////////////////////

    // First operand
    always_comb begin
        case (sel_forward1)
            ex_pkg::FWD_WB:  alu1 = fwd.wb_value;
            ex_pkg::FWD_MEM: alu1 = fwd.mem_value;
            default:         alu1 = data1;
        endcase
    end

    // Second operand before the immediate select
    always_comb begin
        case (sel_forward2)
            ex_pkg::FWD_WB:  fwd2 = fwd.wb_value;
            ex_pkg::FWD_MEM: fwd2 = fwd.mem_value;
            default:         fwd2 = data2;
        endcase
    end

    // Stores write the forwarded rs2 value
    assign save_data = fwd2;

    // Immediate replaces rs2 for I-type and U-type
    assign alu2 = alu_src ? immd : fwd2;

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    alu #(
        .WORD_SIZE (WORD_SIZE)
    ) u_alu (
        .alu_op (alu_op),
        .arg1   (alu1),
        .arg2   (alu2),
        .result (result),
        .zero   (zero),
        .pos    (pos)
    );

endmodule

`default_nettype wire

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module ex_mem_reg #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         id_valid,
    input  logic [$clog2(NUM_REGS)-1:0]  rd,
    input  logic                         reg_write,
    input  logic                         mem_write,
    input  ex_pkg::mem_size_t            data_size,
    input  logic [WORD_SIZE-1:0]         result,
    input  logic [WORD_SIZE-1:0]         save_data,
    input  logic                         zero,
    input  logic                         pos,
    fwd_if.mem_src                       fwd,
    output logic                         mem_valid,
    output logic [$clog2(NUM_REGS)-1:0]  mem_rd,
    output logic                         mem_reg_write,
    output logic                         mem_write_out,
    output ex_pkg::mem_size_t            mem_data_size,
    output logic [WORD_SIZE-1:0]         mem_result,
    output logic [WORD_SIZE-1:0]         mem_save_data,
    output logic                         mem_zero,
    output logic                         mem_pos
);

    // One stage of EX/MEM state
    always_ff @(posedge clk) begin
        if (reset) begin
            mem_valid     <= 1'b0;
            mem_reg_write <= 1'b0;
            mem_write_out <= 1'b0;
            mem_rd        <= '0;
            mem_data_size <= ex_pkg::SIZE_BYTE;
            mem_result    <= '0;
            mem_save_data <= '0;
            mem_zero      <= 1'b0;
            mem_pos       <= 1'b0;
        end else begin
            // Bubble kills the writes
            mem_valid     <= id_valid;
            mem_reg_write <= id_valid & reg_write;
            mem_write_out <= id_valid & mem_write;
            // Payload loads every cycle
            mem_rd        <= rd;
            mem_data_size <= data_size;
            mem_result    <= result;
            mem_save_data <= save_data;
            mem_zero      <= zero;
            mem_pos       <= pos;
        end
    end

    // MEM forwarding source
    assign fwd.mem_rd        = mem_rd;
    assign fwd.mem_reg_write = mem_reg_write;
    assign fwd.mem_value     = mem_result;

endmodule

`default_nettype wire

// ==== design/execute_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module execute_top #(
    parameter int WORD_SIZE = 32,
    parameter int NUM_REGS  = 32
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         id_valid,
    input  logic [$clog2(NUM_REGS)-1:0]  rs1,
    input  logic [$clog2(NUM_REGS)-1:0]  rs2,
    input  logic [$clog2(NUM_REGS)-1:0]  rd,
    input  logic [WORD_SIZE-1:0]         data1,
    input  logic [WORD_SIZE-1:0]         data2,
    input  logic [WORD_SIZE-1:0]         immd,
    input  ex_pkg::alu_op_t              alu_op,
    input  logic                         alu_src,
    input  logic                         reg_write,
    input  logic                         mem_write,
    input  ex_pkg::mem_size_t            data_size,
    input  logic [$clog2(NUM_REGS)-1:0]  wb_rd,
    input  logic                         wb_reg_write,
    input  logic [WORD_SIZE-1:0]         wb_value,
    output logic                         mem_valid,
    output logic [$clog2(NUM_REGS)-1:0]  mem_rd,
    output logic                         mem_reg_write,
    output logic                         mem_write_out,
    output ex_pkg::mem_size_t            mem_data_size,
    output logic [WORD_SIZE-1:0]         mem_result,
    output logic [WORD_SIZE-1:0]         mem_save_data,
    output logic                         mem_zero,
    output logic                         mem_pos
);

    ex_pkg::fwd_sel_t     sel_forward1;
    ex_pkg::fwd_sel_t     sel_forward2;
    logic [WORD_SIZE-1:0] result;
    logic [WORD_SIZE-1:0] save_data;
    logic                 zero;
    logic                 pos;

    fwd_if #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS)) fwd ();

    // WB source comes in on plain ports
    assign fwd.wb_rd        = wb_rd;
    assign fwd.wb_reg_write = wb_reg_write;
    assign fwd.wb_value     = wb_value;

    forward_unit #(.NUM_REGS(NUM_REGS), .WORD_SIZE(WORD_SIZE)) u_forward_unit (
        .rs1 (rs1), .rs2 (rs2), .fwd (fwd.sink),
        .sel_forward1 (sel_forward1), .sel_forward2 (sel_forward2)
    );

    ex_stage #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS)) u_ex_stage (
        .data1 (data1), .data2 (data2), .immd (immd), .fwd (fwd.sink),
        .sel_forward1 (sel_forward1), .sel_forward2 (sel_forward2),
        .alu_op (alu_op), .alu_src (alu_src), .result (result),
        .save_data (save_data), .zero (zero), .pos (pos)
    );

    ex_mem_reg #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(NUM_REGS)) u_ex_mem_reg (
        .clk (clk), .reset (reset), .id_valid (id_valid), .rd (rd),
        .reg_write (reg_write), .mem_write (mem_write), .data_size (data_size),
        .result (result), .save_data (save_data), .zero (zero), .pos (pos),
        .fwd (fwd.mem_src), .mem_valid (mem_valid), .mem_rd (mem_rd),
        .mem_reg_write (mem_reg_write), .mem_write_out (mem_write_out),
        .mem_data_size (mem_data_size), .mem_result (mem_result),
        .mem_save_data (mem_save_data), .mem_zero (mem_zero), .mem_pos (mem_pos)
    );

endmodule

`default_nettype wire

// ==== verif/tb_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_execute;

    localparam int WORD_SIZE = 32;
    localparam int REG_SEL   = 5;

    logic                 clk = 1'b0;
    logic                 reset;
    logic                 id_valid;
    logic [REG_SEL-1:0]   rs1;
    logic [REG_SEL-1:0]   rs2;
    logic [REG_SEL-1:0]   rd;
    logic [WORD_SIZE-1:0] data1;
    logic [WORD_SIZE-1:0] data2;
    logic [WORD_SIZE-1:0] immd;
    ex_pkg::alu_op_t      alu_op;
    logic                 alu_src;
    logic                 reg_write;
    logic                 mem_write;
    ex_pkg::mem_size_t    data_size;
    logic [REG_SEL-1:0]   wb_rd;
    logic                 wb_reg_write;
    logic [WORD_SIZE-1:0] wb_value;
    logic                 mem_valid;
    logic [REG_SEL-1:0]   mem_rd;
    logic                 mem_reg_write;
    logic                 mem_write_out;
    ex_pkg::mem_size_t    mem_data_size;
    logic [WORD_SIZE-1:0] mem_result;
    logic [WORD_SIZE-1:0] mem_save_data;
    logic                 mem_zero;
    logic                 mem_pos;

    // Model copy of the EX/MEM register
    logic                 exp_valid = 1'b0;
    logic [REG_SEL-1:0]   exp_rd = '0;
    logic                 exp_rw = 1'b0;
    logic                 exp_mw = 1'b0;
    logic [1:0]           exp_size = '0;
    logic [WORD_SIZE-1:0] exp_result = '0;
    logic [WORD_SIZE-1:0] exp_save = '0;
    logic                 exp_zero = 1'b0;
    logic                 exp_pos = 1'b0;

    logic [31:0] lfsr_state = 32'd92;
    int          cycle_count = 0;
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          test_checks = 0;

    execute_top #(.WORD_SIZE(WORD_SIZE), .NUM_REGS(32)) dut (
        .clk (clk), .reset (reset), .id_valid (id_valid), .rs1 (rs1), .rs2 (rs2),
        .rd (rd), .data1 (data1), .data2 (data2), .immd (immd), .alu_op (alu_op),
        .alu_src (alu_src), .reg_write (reg_write), .mem_write (mem_write),
        .data_size (data_size), .wb_rd (wb_rd), .wb_reg_write (wb_reg_write),
        .wb_value (wb_value), .mem_valid (mem_valid), .mem_rd (mem_rd),
        .mem_reg_write (mem_reg_write), .mem_write_out (mem_write_out),
        .mem_data_size (mem_data_size), .mem_result (mem_result),
        .mem_save_data (mem_save_data), .mem_zero (mem_zero), .mem_pos (mem_pos)
    );

    always #2 clk = ~clk;

    // Edge counter for the polled waits
    always @(posedge clk) cycle_count <= cycle_count + 1;

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus source
    ////////////////////////////////////////////////////////////////////////////

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < nbits; i++) begin
            if (lfsr_state[0]) lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else lfsr_state = lfsr_state >> 1;
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Small index range so dependences show up often
    task automatic randomize_inputs();
        id_valid     = 1'b1;
        rs1          = REG_SEL'(rand_bits(2));
        rs2          = REG_SEL'(rand_bits(2));
        rd           = REG_SEL'(rand_bits(2));
        data1        = rand_bits(32);
        data2        = rand_bits(32);
        immd         = rand_bits(32);
        alu_op       = ex_pkg::alu_op_t'(4'(rand_bits(4) % 32'd11));
        alu_src      = 1'(rand_bits(1));
        reg_write    = 1'(rand_bits(1));
        mem_write    = 1'(rand_bits(1));
        data_size    = ex_pkg::mem_size_t'(2'(rand_bits(2) % 32'd3));
        wb_rd        = REG_SEL'(rand_bits(2));
        wb_reg_write = 1'(rand_bits(1));
        wb_value     = rand_bits(32);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] model_alu(input ex_pkg::alu_op_t op,
                                              input logic [31:0] a, input logic [31:0] b);
        case (op)
            ex_pkg::ALU_ADD:    return a + b;
            ex_pkg::ALU_SUB:    return a - b;
            ex_pkg::ALU_SLL:    return a << b[4:0];
            ex_pkg::ALU_SLT:    return 32'($signed(a) < $signed(b));
            ex_pkg::ALU_SLTU:   return 32'(a < b);
            ex_pkg::ALU_XOR:    return a ^ b;
            ex_pkg::ALU_SRL:    return a >> b[4:0];
            ex_pkg::ALU_SRA:    return 32'($signed(a) >>> b[4:0]);
            ex_pkg::ALU_OR:     return a | b;
            ex_pkg::ALU_AND:    return a & b;
            ex_pkg::ALU_PASS_B: return b;
            default:            return '0;
        endcase
    endfunction

    // MEM before WB and never x0
    function automatic logic [31:0] pick_operand(input logic [REG_SEL-1:0] rs,
                                                 input logic [31:0] reg_val);
        if (exp_rw && exp_rd != '0 && exp_rd == rs) return exp_result;
        if (wb_reg_write && wb_rd != '0 && wb_rd == rs) return wb_value;
        return reg_val;
    endfunction

    // Next EX/MEM contents from the inputs now on the ports
    task automatic predict();
        logic [31:0] op1;
        logic [31:0] op2;
        op1 = pick_operand(rs1, data1);
        op2 = pick_operand(rs2, data2);
        exp_result = model_alu(alu_op, op1, alu_src ? immd : op2);
        exp_save   = op2;
        exp_zero   = (exp_result == '0);
        exp_pos    = ($signed(exp_result) > 0);
        exp_valid  = id_valid;
        exp_rw     = id_valid && reg_write;
        exp_mw     = id_valid && mem_write;
        exp_rd     = rd;
        exp_size   = data_size;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Checking and timing
    ////////////////////////////////////////////////////////////////////////////

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0.1f ns: %s expected %h, got %h",
                     $realtime, name, expected, actual);
        end
    endtask

    task automatic check_outputs();
        compare("mem_valid", 32'(exp_valid), 32'(mem_valid));
        compare("mem_rd", 32'(exp_rd), 32'(mem_rd));
        compare("mem_reg_write", 32'(exp_rw), 32'(mem_reg_write));
        compare("mem_write_out", 32'(exp_mw), 32'(mem_write_out));
        compare("mem_data_size", 32'(exp_size), 32'(mem_data_size));
        compare("mem_result", exp_result, mem_result);
        compare("mem_save_data", exp_save, mem_save_data);
        compare("mem_zero", 32'(exp_zero), 32'(mem_zero));
        compare("mem_pos", 32'(exp_pos), 32'(mem_pos));
    endtask

    // Polls off the clock edges and lands half a ns after the next rise
    task automatic wait_cycle();
        int start;
        int polls;
        start = cycle_count;
        polls = 0;
        while (cycle_count == start && polls < 20) begin
            #1;
            polls++;
        end
        if (cycle_count == start) begin
            $display("Timeout: no rising clock edge within 20 ns");
            $display("=== FAIL ===");
            $finish;
        end
    endtask

    task automatic step();
        predict();
        wait_cycle();
        check_outputs();
    endtask

    task automatic end_test(input string name);
        $display("%s: %0d checks, %0d errors", name, checks - test_checks,
                 errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        reset = 1'b1;
        randomize_inputs();
        id_valid = 1'b0;
        #0.5;
        repeat (8) wait_cycle();
        reset = 1'b0;
        // Cleared state before any valid input
        check_outputs();
        end_test("reset_state");

        // Every op with no writer anywhere
        for (int i = 0; i < 44; i++) begin
            randomize_inputs();
            reg_write    = 1'b0;
            wb_reg_write = 1'b0;
            alu_op       = ex_pkg::alu_op_t'(4'(i % 11));
            step();
        end
        end_test("alu_ops");

        // Chain through the MEM result
        for (int i = 0; i < 40; i++) begin
            randomize_inputs();
            wb_reg_write = 1'b0;
            reg_write    = 1'b1;
            rd           = REG_SEL'(32'd1 + rand_bits(2) % 32'd3);
            if (1'(rand_bits(1))) rs1 = exp_rd;
            else rs2 = exp_rd;
            step();
        end
        end_test("mem_forward");

        // WB only, then both match, then x0
        for (int i = 0; i < 30; i++) begin
            randomize_inputs();
            wb_reg_write = 1'b1;
            if (i % 3 == 0) begin
                rs1       = REG_SEL'(32'd1 + rand_bits(2) % 32'd3);
                wb_rd     = rs1;
                reg_write = 1'b1;
                rd        = REG_SEL'(32'd1 + rand_bits(2) % 32'd3);
            end else if (i % 3 == 1) begin
                rs2       = exp_rd;
                wb_rd     = exp_rd;
                reg_write = 1'b1;
                rd        = '0;
            end else begin
                rs1       = '0;
                rs2       = '0;
                wb_rd     = '0;
                reg_write = 1'b0;
            end
            step();
        end
        end_test("wb_priority");

        // Bubble with a writer, then a reader of its rd
        for (int i = 0; i < 20; i++) begin
            randomize_inputs();
            wb_reg_write = 1'b0;
            if (i % 2 == 0) begin
                id_valid  = 1'b0;
                reg_write = 1'b1;
                rd        = REG_SEL'(32'd1 + rand_bits(2) % 32'd3);
            end else begin
                rs1 = exp_rd;
                rs2 = exp_rd;
            end
            step();
        end
        end_test("bubbles");

        // Long mixed run
        for (int i = 0; i < 2000; i++) begin
            randomize_inputs();
            id_valid = (rand_bits(2) != 32'd0);
            step();
        end
        end_test("random_mix");

        $display("Total: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== execute.f ====
common/ex_pkg.sv
common/fwd_if.sv
design/forward_unit.sv
ex_stage/alu.sv
ex_stage/ex_stage.sv
design/ex_mem_reg.sv
design/execute_top.sv
verif/tb_execute.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_execute -f execute.f -o tb_execute

out=$(./obj_dir/tb_execute)
echo "$out"

# Pass only on the exact pass line
echo "$out" | grep -qx "=== PASS ==="
